//--- compile.f
design/fb_pkg.sv
design/ctrl_pkg.sv
design/apb_regs.sv
design/fizzle_engine.sv
design/display_timing.sv
design/pixel_path.sv
design/fizzle_top.sv
dv/tb_clk_gen.sv
dv/fizzle_assert.sv
dv/fizzle_tb.sv

//--- Makefile
# Verilator build and run for the fizzle display testbench

VERILATOR ?= verilator
TOP       ?= fizzle_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= FAIL: see errors above

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the fail message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/fizzle_tb.sv
/* fizzle display testbench
   APB register table, framebuffer fill, fade runs and frame scans against a model */

`timescale 1ns/1ps

module fizzle_tb import fb_pkg::*, ctrl_pkg::*; ();

    localparam int FRAME_CYC = int'(H_TOTAL) * int'(V_TOTAL);  // 1120
    localparam int FADE_RATE = 4;
    localparam int NPIX      = int'(FB_PIXELS);
    localparam int NPAL      = 2**CIDXW;
    localparam int DRV_DLY   = 2;  // ns after the rising edge

    typedef struct packed {
        logic [APB_ADDRW-1:0] addr;
        logic [APB_DATAW-1:0] wdata;
        logic                 write;
        logic [APB_DATAW-1:0] exp_rdata;  // reads without error only
        logic                 exp_err;
    } apb_op_t;

    logic                 clk_sys;
    logic                 arst_n;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [APB_ADDRW-1:0] paddr;
    logic [APB_DATAW-1:0] pwdata;
    logic [APB_DATAW-1:0] prdata;
    logic                 pready;
    logic                 pslverr;
    logic                 hsync;
    logic                 vsync;
    logic                 de;
    logic [CHANW-1:0]     vga_r;
    logic [CHANW-1:0]     vga_g;
    logic [CHANW-1:0]     vga_b;
    logic                 frame;

    apb_op_t     ops [$];
    cidx_t       model_fb [NPIX];   // what the fb should hold
    colr_t       model_pal [NPAL];
    logic [31:0] rng;
    int          mismatches;
    int          failures;
    int          checks;
    int          cycles;
    int          cycle_limit;

    tb_clk_gen clk_gen_i (.clk_sys, .arst_n);

    fizzle_top dut_i (
        .clk_sys, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .hsync, .vsync, .de,
        .vga_r, .vga_g, .vga_b, .frame
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_colr(input string name, input colr_t got, input colr_t exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %03h expected %03h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [APB_DATAW-1:0] got,
                              input logic [APB_DATAW-1:0] exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %08h expected %08h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            mismatches++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // one APB3 transfer, entered and left DRV_DLY after a rising edge
    task automatic apb_xfer(input logic [APB_ADDRW-1:0] addr, input logic [APB_DATAW-1:0] wdata,
                            input logic write, output logic [APB_DATAW-1:0] rdata,
                            output logic err);
        int n;
        n       = 0;
        psel    = 1'b1;   // setup phase
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk_sys);
        #DRV_DLY;
        penable = 1'b1;
        @(negedge clk_sys);  // mid-cycle, outputs settled
        while (!pready && n < 8) begin
            n++;
            @(negedge clk_sys);
        end
        if (!pready) begin
            failures++;
            $display("ERROR: no pready for APB access to %02h at %0t", addr, $time);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk_sys);
        #DRV_DLY;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic write_reg(input logic [APB_ADDRW-1:0] addr, input logic [APB_DATAW-1:0] data,
                             input logic exp_err);
        logic [APB_DATAW-1:0] rd;
        logic                 err;
        apb_xfer(addr, data, 1'b1, rd, err);
        check_flag($sformatf("pslverr write %02h", addr), err, exp_err);
    endtask

    task automatic read_reg(input logic [APB_ADDRW-1:0] addr, output logic [APB_DATAW-1:0] data,
                            input logic exp_err);
        logic err;
        apb_xfer(addr, '0, 1'b0, data, err);
        check_flag($sformatf("pslverr read %02h", addr), err, exp_err);
    endtask

    task automatic add_op(input logic [APB_ADDRW-1:0] addr, input logic [APB_DATAW-1:0] wdata,
                          input logic write, input logic [APB_DATAW-1:0] exp_rdata,
                          input logic exp_err);
        ops.push_back('{addr, wdata, write, exp_rdata, exp_err});
    endtask

    // register access rules, idle engine straight after reset
    task automatic build_table();
        add_op(REG_FADE_COLR, 32'h0000_0009, 1'b1, 32'h0, 1'b0);
        add_op(REG_FADE_COLR, 32'h0,         1'b0, 32'h9, 1'b0);
        add_op(REG_FADE_RATE, 32'h0000_1234, 1'b1, 32'h0, 1'b0);
        add_op(REG_FADE_RATE, 32'h0,         1'b0, 32'h1234, 1'b0);
        add_op(REG_FADE_COLR, 32'hffff_fff3, 1'b1, 32'h0, 1'b0);  // 4 bits kept
        add_op(REG_FADE_COLR, 32'h0,         1'b0, 32'h3, 1'b0);
        add_op(8'h20,         32'h0000_dead, 1'b1, 32'h0, 1'b1);  // unmapped
        add_op(8'h20,         32'h0,         1'b0, 32'h0, 1'b1);
        add_op(8'h41,         32'h0000_0fff, 1'b1, 32'h0, 1'b1);  // off the palette stride
        add_op(8'h80,         32'h0000_0001, 1'b1, 32'h0, 1'b1);
        add_op(REG_STATUS,    32'h0000_0003, 1'b1, 32'h0, 1'b1);  // read-only
        add_op(REG_STATUS,    32'h0,         1'b0, 32'h0, 1'b0);
        add_op(REG_WR_COUNT,  32'h0000_00ff, 1'b1, 32'h0, 1'b1);
        add_op(REG_WR_COUNT,  32'h0,         1'b0, 32'h0, 1'b0);
        add_op(REG_FB_ADDR,   32'h0000_002a, 1'b1, 32'h0, 1'b0);
        add_op(REG_FB_DATA,   32'h0,         1'b0, 32'h0, 1'b1);  // write-only
        add_op(REG_PAL_BASE,  32'h0,         1'b0, 32'h0, 1'b1);
        add_op(REG_FB_ADDR,   32'h0,         1'b0, 32'h2a, 1'b0);
        add_op(REG_FADE_RATE, 32'h0,         1'b0, 32'h1234, 1'b0);  // untouched by errors
        add_op(REG_CTRL,      32'h0,         1'b1, 32'h0, 1'b0);  // bit 0 clear, no start
    endtask

    task automatic apply_op(input apb_op_t op);
        logic [APB_DATAW-1:0] rd;
        logic                 err;
        apb_xfer(op.addr, op.wdata, op.write, rd, err);
        check_flag($sformatf("pslverr op %02h", op.addr), err, op.exp_err);
        if (!op.write && !op.exp_err)
            check_word($sformatf("prdata %02h", op.addr), rd, op.exp_rdata);
    endtask

    task automatic wait_fade_done(input int max_polls);
        logic [APB_DATAW-1:0] st;
        int                   n;
        st = '0;
        n  = 0;
        while (!st[1] && n < max_polls) begin
            read_reg(REG_STATUS, st, 1'b0);
            n++;
        end
        if (!st[1]) begin
            failures++;
            $display("ERROR: fade not done after %0d status polls", max_polls);
        end
        check_flag("status busy", st[0], 1'b0);
        check_flag("status done", st[1], 1'b1);
    endtask

    // one full frame from the frame pulse, outputs trail the raster by PIX_LAT
    task automatic scan_frame();
        int   n;
        int   pix;
        int   run;
        int   lines;
        int   hs_cnt;
        int   vs_cnt;
        int   x;
        int   y;
        logic prev_hs;
        logic prev_vs;
        {n, pix, run, lines, hs_cnt, vs_cnt} = '0;
        prev_hs = 1'b0;
        prev_vs = 1'b0;
        @(negedge clk_sys);
        while (!frame && n < FRAME_CYC) begin
            n++;
            @(negedge clk_sys);
        end
        if (!frame) begin
            failures++;
            $display("ERROR: no frame pulse within one frame time at %0t", $time);
        end else begin
            for (int t = 1; t < FRAME_CYC + PIX_LAT; t++) begin
                @(negedge clk_sys);
                if (t >= PIX_LAT) begin
                    if (hsync && !prev_hs) hs_cnt++;
                    if (vsync && !prev_vs) vs_cnt++;
                    if (de) begin
                        x = pix % int'(H_ACTIVE);
                        y = pix / int'(H_ACTIVE);
                        if (pix < int'(H_ACTIVE) * int'(V_ACTIVE))
                            check_colr($sformatf("pixel(%0d,%0d)", x, y), {vga_r, vga_g, vga_b},
                                model_pal[model_fb[fb_addr_t'((y / FB_SCALE) * FB_WIDTH
                                    + x / FB_SCALE)]]);
                        pix++;
                        run++;
                    end else if (run != 0) begin
                        check_word($sformatf("de run of line %0d", lines), 32'(run),
                            32'(H_ACTIVE));
                        lines++;
                        run = 0;
                    end
                end
                prev_hs = hsync;
                prev_vs = vsync;
            end
            check_word("active lines", 32'(lines), 32'(V_ACTIVE));
            check_word("active pixels", 32'(pix), 32'(int'(H_ACTIVE) * int'(V_ACTIVE)));
            check_word("hsync pulses", 32'(hs_cnt), 32'(V_TOTAL));
            check_word("vsync pulses", 32'(vs_cnt), 32'd1);
        end
        @(posedge clk_sys);
        #DRV_DLY;
    endtask

    task automatic report_counts();
        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, failures);
    endtask

    initial begin
        logic [APB_DATAW-1:0] rd;
        int                   max_polls;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        rng     = 32'hc66a6aa3;
        {mismatches, failures, checks} = '0;
        build_table();
        cycle_limit = 8 * FRAME_CYC + 255 * FADE_RATE + ops.size() * 4;
        max_polls   = 255 * FADE_RATE / 2 + 32;  // two cycles per poll
        wait (arst_n === 1'b1);
        @(posedge clk_sys);
        #DRV_DLY;

        foreach (ops[i]) apply_op(ops[i]);

        // random image and palette
        write_reg(REG_FB_ADDR, 32'h0, 1'b0);
        for (int i = 0; i < NPIX; i++) begin
            rng = xorshift32(rng);
            model_fb[fb_addr_t'(i)] = rng[CIDXW-1:0];
            write_reg(REG_FB_DATA, APB_DATAW'(model_fb[fb_addr_t'(i)]), 1'b0);
        end
        read_reg(REG_FB_ADDR, rd, 1'b0);
        check_word("fb_addr after fill", rd, APB_DATAW'(NPIX));
        for (int i = 0; i < NPAL; i++) begin
            rng = xorshift32(rng);
            model_pal[cidx_t'(i)] = rng[COLRW-1:0];
            write_reg(REG_PAL_BASE + APB_ADDRW'(4 * i), APB_DATAW'(model_pal[cidx_t'(i)]), 1'b0);
        end
        scan_frame();

        // first fade
        write_reg(REG_FADE_COLR, 32'h5, 1'b0);
        write_reg(REG_FADE_RATE, APB_DATAW'(FADE_RATE), 1'b0);
        write_reg(REG_CTRL, 32'h1, 1'b0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status busy", rd[0], 1'b1);
        check_flag("status done", rd[1], 1'b0);
        write_reg(REG_FB_DATA, 32'h3, 1'b1);  // fb belongs to the fade
        read_reg(REG_FB_ADDR, rd, 1'b0);
        check_word("fb_addr after refused write", rd, APB_DATAW'(NPIX));
        wait_fade_done(max_polls);
        read_reg(REG_WR_COUNT, rd, 1'b0);
        check_word("wr_count", rd, APB_DATAW'(NPIX));
        for (int i = 0; i < NPIX; i++) model_fb[fb_addr_t'(i)] = cidx_t'(5);
        scan_frame();

        // restart clears done and the write count
        write_reg(REG_CTRL, 32'h1, 1'b0);
        read_reg(REG_WR_COUNT, rd, 1'b0);
        check_word("wr_count after restart", rd, 32'h0);
        read_reg(REG_STATUS, rd, 1'b0);
        check_flag("status busy", rd[0], 1'b1);
        check_flag("status done", rd[1], 1'b0);
        wait_fade_done(max_polls);
        read_reg(REG_WR_COUNT, rd, 1'b0);
        check_word("wr_count", rd, APB_DATAW'(NPIX));

        report_counts();
        if (mismatches == 0 && failures == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    // watchdog
    initial begin
        cycles = 0;
        wait (cycle_limit != 0);
        while (cycles <= cycle_limit) begin
            @(posedge clk_sys);
            cycles++;
        end
        $display("ERROR: timeout after %0d cycles", cycles);
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- dv/fizzle_assert.sv
/* bound checks on the fizzle top
   APB ready and display blanking rules */

`timescale 1ns/1ps

module fizzle_assert import fb_pkg::*; (
    input logic             clk_sys,
    input logic             arst_n,
    input logic             psel,
    input logic             penable,
    input logic             pready,
    input logic             hsync,
    input logic             vsync,
    input logic             de,
    input logic [CHANW-1:0] vga_r,
    input logic [CHANW-1:0] vga_g,
    input logic [CHANW-1:0] vga_b
);

    // zero wait states, each setup phase is followed by an access phase that completes
    a_pready: assert property (@(posedge clk_sys) disable iff (!arst_n)
        (psel && !penable) |=> (psel && penable && pready))
        else $error("APB setup phase not followed by a ready access phase");

    // sync pulses sit in blanking
    a_de_sync: assert property (@(posedge clk_sys) disable iff (!arst_n)
        !(de && (hsync || vsync)))
        else $error("de high during hsync or vsync");

    a_black: assert property (@(posedge clk_sys) disable iff (!arst_n)
        !de |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
        else $error("colour output not black while de is low");

endmodule

bind fizzle_top fizzle_assert assert_i (
    .clk_sys, .arst_n, .psel, .penable, .pready,
    .hsync, .vsync, .de, .vga_r, .vga_g, .vga_b
);

//--- dv/tb_clk_gen.sv
/* testbench clock and reset
   40 ns clk_sys, arst_n held low for the first 16 cycles */

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_sys,
    output logic arst_n
);

    localparam int HALF_PERIOD = 20;  // ns
    localparam int RST_CYCLES  = 16;

    initial begin
        clk_sys = 1'b0;
        forever #HALF_PERIOD clk_sys = ~clk_sys;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_sys);
        #2 arst_n = 1'b1;  // released off the edge, like the other inputs
    end

endmodule

//--- design/fizzle_top.sv
/* fizzle display top
   APB register block, fade engine, display timing and pixel path */

`timescale 1ns/1ps

module fizzle_top import fb_pkg::*, ctrl_pkg::*; (
    input  logic                 clk_sys,   // also the pixel clock
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [APB_ADDRW-1:0] paddr,
    input  logic [APB_DATAW-1:0] pwdata,
    output logic [APB_DATAW-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 de,
    output logic [CHANW-1:0]     vga_r,
    output logic [CHANW-1:0]     vga_g,
    output logic [CHANW-1:0]     vga_b,
    output logic                 frame
);

    logic                fade_start;
    cidx_t               fade_colr;
    logic [RATE_W-1:0]   fade_rate;
    logic                fade_busy;
    logic                fade_done;
    logic [FB_ADDRW-1:0] wr_count;
    logic                host_we;
    fb_addr_t            host_addr;
    cidx_t               host_cidx;
    logic                pal_we;
    cidx_t               pal_idx;
    colr_t               pal_colr;
    logic                fade_we;
    fb_addr_t            fade_addr;
    cidx_t               fade_cidx;
    logic [CORDW-1:0]    sx;
    logic [CORDW-1:0]    sy;
    logic                hsync_raw;
    logic                vsync_raw;
    logic                de_raw;

    apb_regs regs_i (
        .clk_sys, .arst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr, .fade_busy, .fade_done, .wr_count,
        .fade_start, .fade_colr, .fade_rate, .host_we, .host_addr, .host_cidx,
        .pal_we, .pal_idx, .pal_colr
    );

    fizzle_engine engine_i (
        .clk_sys, .arst_n, .fade_start, .fade_colr, .fade_rate,
        .fade_busy, .fade_done, .wr_count, .fade_we, .fade_addr, .fade_cidx
    );

    display_timing timing_i (
        .clk_sys, .arst_n, .sx, .sy, .hsync_raw, .vsync_raw, .de_raw,
        .frame_start(frame)
    );

    pixel_path pixel_i (
        .clk_sys, .arst_n, .sx, .sy, .hsync_raw, .vsync_raw, .de_raw,
        .fade_we, .fade_addr, .fade_cidx, .host_we, .host_addr, .host_cidx,
        .pal_we, .pal_idx, .pal_colr, .hsync, .vsync, .de, .vga_r, .vga_g, .vga_b
    );

endmodule

//--- design/pixel_path.sv
/* pixel path
   framebuffer, scaled read, palette lookup and registered display outputs */

`timescale 1ns/1ps

module pixel_path import fb_pkg::*; (
    input  logic             clk_sys,
    input  logic             arst_n,
    input  logic [CORDW-1:0] sx,
    input  logic [CORDW-1:0] sy,
    input  logic             hsync_raw,
    input  logic             vsync_raw,
    input  logic             de_raw,
    input  logic             fade_we,
    input  fb_addr_t         fade_addr,
    input  cidx_t            fade_cidx,
    input  logic             host_we,
    input  fb_addr_t         host_addr,
    input  cidx_t            host_cidx,
    input  logic             pal_we,
    input  cidx_t            pal_idx,
    input  colr_t            pal_colr,
    output logic             hsync,
    output logic             vsync,
    output logic             de,
    output logic [CHANW-1:0] vga_r,
    output logic [CHANW-1:0] vga_g,
    output logic [CHANW-1:0] vga_b
);

    cidx_t    fb_mem [0:FB_PIXELS-1];
    colr_t    pal [0:(2**CIDXW)-1];

    logic     wr_en;
    fb_addr_t wr_addr;
    cidx_t    wr_cidx;
    fb_addr_t rd_addr_c;
    fb_addr_t rd_addr_q;   // stage 1
    cidx_t    fb_cidx_q;   // stage 2
    colr_t    paint_q;     // stage 3

    logic [PIX_LAT-1:0] hs_pipe;
    logic [PIX_LAT-1:0] vs_pipe;
    logic [PIX_LAT-1:0] de_pipe;

    // fade wins, host writes are refused while it runs
    assign wr_en   = fade_we || host_we;
    assign wr_addr = fade_we ? fade_addr : host_addr;
    assign wr_cidx = fade_we ? fade_cidx : host_cidx;

    always_ff @(posedge clk_sys) begin
        if (wr_en && wr_addr < FB_PIXELS)  // host pointer can run past the end
            fb_mem[wr_addr] <= wr_cidx;
    end

    // (sy/2)*16 + sx/2, parked at 0 in blanking
    always_comb begin
        if (de_raw)
            rd_addr_c = FB_ADDRW'((sy / FB_SCALE) * FB_WIDTH + sx / FB_SCALE);
        else
            rd_addr_c = '0;
    end

    always_ff @(posedge clk_sys) begin
        rd_addr_q <= rd_addr_c;
        fb_cidx_q <= fb_mem[rd_addr_q];
    end

    // palette register file, cleared to black
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**CIDXW; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_we) begin
            pal[pal_idx] <= pal_colr;
        end
    end

    // sync and de ride alongside the three data stages
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            hs_pipe <= '0;
            vs_pipe <= '0;
            de_pipe <= '0;
            paint_q <= '0;
        end else begin
            hs_pipe <= {hs_pipe[PIX_LAT-2:0], hsync_raw};
            vs_pipe <= {vs_pipe[PIX_LAT-2:0], vsync_raw};
            de_pipe <= {de_pipe[PIX_LAT-2:0], de_raw};
            // black outside the active area
            paint_q <= de_pipe[PIX_LAT-2] ? pal[fb_cidx_q] : '0;
        end
    end

    assign hsync = hs_pipe[PIX_LAT-1];
    assign vsync = vs_pipe[PIX_LAT-1];
    assign de    = de_pipe[PIX_LAT-1];

    assign vga_r = paint_q[3*CHANW-1:2*CHANW];
    assign vga_g = paint_q[2*CHANW-1:CHANW];
    assign vga_b = paint_q[CHANW-1:0];

endmodule

//--- design/display_timing.sv
/* display timing generator
   scans a 40x28 raster with a 32x24 active area, gives sync and data enable */

`timescale 1ns/1ps

module display_timing import fb_pkg::*; (
    input  logic             clk_sys,
    input  logic             arst_n,
    output logic [CORDW-1:0] sx,
    output logic [CORDW-1:0] sy,
    output logic             hsync_raw,
    output logic             vsync_raw,
    output logic             de_raw,
    output logic             frame_start
);

    logic line_end;

    assign line_end = (sx == H_TOTAL - 1'b1);

    // raster counters, active area first then blanking
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else begin
            if (line_end) begin
                sx <= '0;
                sy <= (sy == V_TOTAL - 1'b1) ? '0 : sy + 1'b1;
            end else begin
                sx <= sx + 1'b1;
            end
        end
    end

    // sync active high from start up to but not including end
    assign hsync_raw = (sx >= H_SYNC_START) && (sx < H_SYNC_END);
    assign vsync_raw = (sy >= V_SYNC_START) && (sy < V_SYNC_END);
    assign de_raw    = (sx < H_ACTIVE) && (sy < V_ACTIVE);

    assign frame_start = (sx == '0) && (sy == '0);

endmodule

//--- design/fizzle_engine.sv
/* fizzle fade engine
   steps an 8-bit lfsr and paints each framebuffer pixel once with the fade colour */

`timescale 1ns/1ps

module fizzle_engine import fb_pkg::*, ctrl_pkg::*; (
    input  logic                clk_sys,
    input  logic                arst_n,
    input  logic                fade_start,
    input  cidx_t               fade_colr,
    input  logic [RATE_W-1:0]   fade_rate,
    output logic                fade_busy,
    output logic                fade_done,
    output logic [FB_ADDRW-1:0] wr_count,
    output logic                fade_we,
    output fb_addr_t            fade_addr,
    output cidx_t               fade_cidx
);

    fade_state_e       state;
    logic [7:0]        lfsr;
    logic [7:0]        lfsr_next;
    fb_addr_t          lfsr_addr;   // lfsr value mapped to fb address
    logic              in_range;
    logic [RATE_W-1:0] rate_cnt;
    logic [RATE_W-1:0] rate_m1;     // wait cycles between steps

    // rate 0 behaves as rate 1
    assign rate_m1 = (fade_rate == '0) ? '0 : fade_rate - 1'b1;

    // galois shift right, taps folded in when the lsb falls out
    assign lfsr_next = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
    assign lfsr_addr = lfsr - 1'b1;          // lfsr never holds 0
    assign in_range  = lfsr_addr < FB_PIXELS;

    assign fade_busy = (state == FZ_WAIT) || (state == FZ_STEP);
    assign fade_done = (state == FZ_DONE);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state    <= FZ_IDLE;
            lfsr     <= '0;
            rate_cnt <= '0;
            wr_count <= '0;
            fade_we  <= 1'b0;
        end else begin
            fade_we <= 1'b0;
            case (state)
                FZ_IDLE, FZ_DONE: begin
                    if (fade_start) begin
                        lfsr     <= LFSR_SEED;
                        rate_cnt <= '0;
                        wr_count <= '0;  // count since this start
                        state    <= (rate_m1 == '0) ? FZ_STEP : FZ_WAIT;
                    end
                end
                FZ_WAIT: begin
                    rate_cnt <= rate_cnt + 1'b1;
                    if (rate_cnt >= rate_m1 - 1'b1) state <= FZ_STEP;
                end
                FZ_STEP: begin
                    fade_we  <= in_range;  // skip addresses past the fb
                    if (in_range) wr_count <= wr_count + 1'b1;
                    lfsr     <= lfsr_next;
                    rate_cnt <= '0;
                    // back at the seed after 255 steps
                    if (lfsr_next == LFSR_SEED)
                        state <= FZ_DONE;
                    else if (rate_m1 != '0)
                        state <= FZ_WAIT;
                end
                default: state <= FZ_IDLE;
            endcase
        end
    end

    // write payload, valid with fade_we
    always_ff @(posedge clk_sys) begin
        if (state == FZ_STEP) begin
            fade_addr <= lfsr_addr;
            fade_cidx <= fade_colr;
        end
    end

endmodule

//--- design/apb_regs.sv
/* apb register block
   decodes APB3 accesses, holds fade settings and issues fb and palette writes */

`timescale 1ns/1ps

module apb_regs import fb_pkg::*, ctrl_pkg::*; (
    input  logic                 clk_sys,
    input  logic                 arst_n,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [APB_ADDRW-1:0] paddr,
    input  logic [APB_DATAW-1:0] pwdata,
    output logic [APB_DATAW-1:0] prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic                 fade_busy,
    input  logic                 fade_done,
    input  logic [FB_ADDRW-1:0]  wr_count,
    output logic                 fade_start,
    output cidx_t                fade_colr,
    output logic [RATE_W-1:0]    fade_rate,
    output logic                 host_we,
    output fb_addr_t             host_addr,
    output cidx_t                host_cidx,
    output logic                 pal_we,
    output cidx_t                pal_idx,
    output colr_t                pal_colr
);

    reg_sel_e sel;
    logic     access;   // apb access phase
    logic     err;
    logic     wr_ok;    // accepted write, takes effect this edge
    fb_addr_t fb_addr;  // host write pointer

    always_comb begin
        case (paddr)
            REG_CTRL:      sel = SEL_CTRL;
            REG_FADE_COLR: sel = SEL_FADE_COLR;
            REG_FADE_RATE: sel = SEL_FADE_RATE;
            REG_STATUS:    sel = SEL_STATUS;
            REG_WR_COUNT:  sel = SEL_WR_COUNT;
            REG_FB_ADDR:   sel = SEL_FB_ADDR;
            REG_FB_DATA:   sel = SEL_FB_DATA;
            default: begin
                // palette window 0x40..0x7c, word aligned only
                if (paddr[APB_ADDRW-1 -: 2] == REG_PAL_BASE[APB_ADDRW-1 -: 2]
                        && paddr[1:0] == 2'b00)
                    sel = SEL_PAL;
                else
                    sel = SEL_NONE;
            end
        endcase
    end

    assign access = psel && penable;
    assign err = (sel == SEL_NONE)
        || (pwrite && (sel == SEL_STATUS || sel == SEL_WR_COUNT))
        || (!pwrite && (sel == SEL_CTRL || sel == SEL_FB_DATA || sel == SEL_PAL))
        || (pwrite && sel == SEL_FB_DATA && fade_busy);  // fb owned by the fade
    assign wr_ok = access && pwrite && !err;

    assign pready  = access;  // zero wait states
    assign pslverr = access && err;

    always_comb begin
        case (sel)
            SEL_FADE_COLR: prdata = APB_DATAW'(fade_colr);
            SEL_FADE_RATE: prdata = APB_DATAW'(fade_rate);
            SEL_STATUS:    prdata = APB_DATAW'({fade_done, fade_busy});
            SEL_WR_COUNT:  prdata = APB_DATAW'(wr_count);
            SEL_FB_ADDR:   prdata = APB_DATAW'(fb_addr);
            default:       prdata = '0;
        endcase
    end

    // control registers and write strobes
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            fade_colr  <= '0;
            fade_rate  <= '0;
            fb_addr    <= '0;
            fade_start <= 1'b0;
            host_we    <= 1'b0;
            pal_we     <= 1'b0;
        end else begin
            fade_start <= wr_ok && sel == SEL_CTRL && pwdata[0] && !fade_busy;
            host_we    <= wr_ok && sel == SEL_FB_DATA;
            pal_we     <= wr_ok && sel == SEL_PAL;
            if (wr_ok && sel == SEL_FADE_COLR) fade_colr <= pwdata[CIDXW-1:0];
            if (wr_ok && sel == SEL_FADE_RATE) fade_rate <= pwdata[RATE_W-1:0];
            if (wr_ok && sel == SEL_FB_ADDR)
                fb_addr <= pwdata[FB_ADDRW-1:0];
            else if (wr_ok && sel == SEL_FB_DATA)
                fb_addr <= fb_addr + 1'b1;  // next pixel
        end
    end

    // write payload, qualified by the strobes above
    always_ff @(posedge clk_sys) begin
        if (wr_ok && sel == SEL_FB_DATA) begin
            host_addr <= fb_addr;
            host_cidx <= pwdata[CIDXW-1:0];
        end
        if (wr_ok && sel == SEL_PAL) begin
            pal_idx  <= paddr[CIDXW+1:2];  // word index in the window
            pal_colr <= pwdata[COLRW-1:0];
        end
    end

endmodule

//--- design/ctrl_pkg.sv
/* control package
   APB register map, LFSR constants and control enums */

package ctrl_pkg;

    localparam int APB_ADDRW = 8;
    localparam int APB_DATAW = 32;

    // register offsets
    localparam logic [APB_ADDRW-1:0] REG_CTRL      = 8'h00;  // wo, bit 0 starts the fade
    localparam logic [APB_ADDRW-1:0] REG_FADE_COLR = 8'h04;
    localparam logic [APB_ADDRW-1:0] REG_FADE_RATE = 8'h08;  // cycles per lfsr step
    localparam logic [APB_ADDRW-1:0] REG_STATUS    = 8'h0C;  // ro, {done, busy}
    localparam logic [APB_ADDRW-1:0] REG_WR_COUNT  = 8'h10;  // ro
    localparam logic [APB_ADDRW-1:0] REG_FB_ADDR   = 8'h14;
    localparam logic [APB_ADDRW-1:0] REG_FB_DATA   = 8'h18;  // wo, auto increment
    localparam logic [APB_ADDRW-1:0] REG_PAL_BASE  = 8'h40;  // 16 words, wo

    // x^8 + x^6 + x^5 + x^4 + 1, galois form
    localparam logic [7:0] LFSR_TAPS = 8'hB8;
    localparam logic [7:0] LFSR_SEED = 8'h01;

    localparam int RATE_W = 16;

    typedef enum logic [3:0] {
        SEL_CTRL, SEL_FADE_COLR, SEL_FADE_RATE, SEL_STATUS, SEL_WR_COUNT,
        SEL_FB_ADDR, SEL_FB_DATA, SEL_PAL, SEL_NONE
    } reg_sel_e;

    typedef enum logic [1:0] {
        FZ_IDLE, FZ_WAIT, FZ_STEP, FZ_DONE
    } fade_state_e;

endpackage

//--- design/fb_pkg.sv
/* framebuffer package
   raster geometry, framebuffer size, colour widths and pixel-path latency */

package fb_pkg;

    // colour
    localparam int CIDXW = 4;            // colour index bits
    localparam int CHANW = 4;            // bits per channel
    localparam int COLRW = 3 * CHANW;    // r, g, b packed

    // framebuffer
    localparam int FB_WIDTH  = 16;
    localparam int FB_HEIGHT = 12;
    localparam int FB_SCALE  = 2;        // each fb pixel covers 2x2 raster pixels
    localparam int FB_ADDRW  = 8;
    localparam logic [FB_ADDRW-1:0] FB_PIXELS = FB_ADDRW'(FB_WIDTH * FB_HEIGHT);  // 192

    // raster, all coordinates fit in CORDW bits
    localparam int CORDW = 6;
    localparam logic [CORDW-1:0] H_ACTIVE     = CORDW'(FB_WIDTH * FB_SCALE);   // 32
    localparam logic [CORDW-1:0] V_ACTIVE     = CORDW'(FB_HEIGHT * FB_SCALE);  // 24
    localparam logic [CORDW-1:0] H_TOTAL      = 6'd40;
    localparam logic [CORDW-1:0] V_TOTAL      = 6'd28;
    localparam logic [CORDW-1:0] H_SYNC_START = 6'd34;
    localparam logic [CORDW-1:0] H_SYNC_END   = 6'd37;
    localparam logic [CORDW-1:0] V_SYNC_START = 6'd25;
    localparam logic [CORDW-1:0] V_SYNC_END   = 6'd26;

    // address reg, fb + palette read, paint reg
    localparam int PIX_LAT = 3;

    typedef logic [CIDXW-1:0]    cidx_t;
    typedef logic [COLRW-1:0]    colr_t;
    typedef logic [FB_ADDRW-1:0] fb_addr_t;

endpackage
